// ==== hw/fpAddPkg.sv ====
// Operand, unpacked, aligned and sum structs, alignment limit and controller states
`default_nettype none

package fpAddPkg;

    // Largest serial shift, beyond it only sticky changes
    localparam int maxAlignShift = 26;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fpOperandT;

    typedef struct packed {
        logic        bigSign;
        logic [7:0]  bigExponent;
        logic [23:0] bigMantissa;     // Hidden bit included
        logic [23:0] smallMantissa;   // Hidden bit included
        logic [7:0]  expDiff;
        logic        effSub;          // Signs differ after sub inversion
    } unpackedT;

    typedef struct packed {
        logic [23:0] shiftedMantissa;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
    } alignedT;

    // Same field names as the normalize bus
    typedef struct packed {
        logic [23:0] alignedResult;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic        carryOut;
        logic [7:0]  exponentOut;
        logic        alignedSign;
    } sumT;

    typedef enum logic [2:0] {IDLE, UNPACK, ALIGN, ADD, NORM, DONE} ctrlStateT;

endpackage

`default_nettype wire

// ==== hw/fpAddCtrl.sv ====
// Sequencing FSM for capture, alignment, addition and normalization, with busy and done
`timescale 1ns/10ps
`default_nettype none

module fpAddCtrl (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  logic countZero,
    output logic captureEn,
    output logic loadCount,
    output logic shiftEn,
    output logic addEn,
    output logic normEn,
    output logic busy,
    output logic done
);
    import fpAddPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            state <= IDLE;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            IDLE:    if (start) nextState = UNPACK;
            UNPACK:  nextState = ALIGN;
            ALIGN:   if (countZero) nextState = ADD;   // Wait for last shift
            ADD:     nextState = NORM;
            NORM:    nextState = DONE;
            DONE:    nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    // Operands follow the inputs until start leaves IDLE
    assign captureEn = (state == IDLE);
    assign loadCount = (state == UNPACK);
    assign shiftEn   = (state == ALIGN) && !countZero;
    assign addEn     = (state == ADD);
    assign normEn    = (state == NORM);
    assign busy      = (state != IDLE);
    assign done      = (state == DONE);

    // One done per accepted start
    doneSinglePulse: assert property (@(posedge clk) disable iff (!arstN)
        done |=> !done)
        else $error("done held for two cycles");

endmodule

`default_nettype wire

// ==== hw/alignCounter.sv ====
// Loadable down-counter of remaining alignment shifts with zero flag
`timescale 1ns/10ps
`default_nettype none

module alignCounter #(
    parameter int countWidth = 5
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       loadCount,
    input  logic       shiftEn,
    input  logic [7:0] expDiff,
    output logic       countZero
);
    import fpAddPkg::*;

    logic [countWidth-1:0] count;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            count <= '0;
        else if (loadCount)
            count <= (expDiff > maxAlignShift) ? countWidth'(maxAlignShift)
                                               : countWidth'(expDiff);
        else if (shiftEn)
            count <= count - 1'b1;
    end

    assign countZero = (count == '0);

    // FSM must stop shifting once the count runs out
    noUnderflow: assert property (@(posedge clk) disable iff (!arstN)
        shiftEn && !loadCount |-> count != '0)
        else $error("alignment counter decremented below zero");

endmodule

`default_nettype wire

// ==== hw/fpUnpack.sv ====
// Operand capture with hidden bit restore, magnitude ordering and exponent difference
`timescale 1ns/10ps
`default_nettype none

module fpUnpack (
    input  logic                clk,
    input  logic                arstN,
    input  logic                captureEn,
    input  fpAddPkg::fpOperandT opA,
    input  fpAddPkg::fpOperandT opB,
    input  logic                sub,
    output fpAddPkg::unpackedT  unpacked,
    output fpAddPkg::fpOperandT rawA,
    output fpAddPkg::fpOperandT rawB
);
    import fpAddPkg::*;

    fpOperandT   effB;      // B with sign flipped for subtraction
    logic [23:0] mantA;
    logic [23:0] mantB;
    logic        aFirst;

    always_comb
    begin
        effB = opB;
        effB.sign = opB.sign ^ sub;
        mantA = {|opA.exponent, opA.mantissa};   // No hidden bit for exponent 0
        mantB = {|effB.exponent, effB.mantissa};
        aFirst = (opA.exponent > effB.exponent) ||
                 ((opA.exponent == effB.exponent) && (mantA >= mantB));
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rawA <= '0;
            rawB <= '0;
            unpacked <= '0;
        end
        else if (captureEn)
        begin
            rawA <= opA;
            rawB <= effB;
            unpacked.bigSign <= aFirst ? opA.sign : effB.sign;
            unpacked.bigExponent <= aFirst ? opA.exponent : effB.exponent;
            unpacked.bigMantissa <= aFirst ? mantA : mantB;
            unpacked.smallMantissa <= aFirst ? mantB : mantA;
            unpacked.expDiff <= aFirst ? (opA.exponent - effB.exponent)
                                       : (effB.exponent - opA.exponent);
            unpacked.effSub <= opA.sign ^ effB.sign;
        end
    end

endmodule

`default_nettype wire

// ==== hw/alignShifter.sv ====
// Serial right shifter of the smaller mantissa collecting guard, round and sticky
`timescale 1ns/10ps
`default_nettype none

module alignShifter (
    input  logic               clk,
    input  logic               arstN,
    input  logic               loadCount,
    input  logic               shiftEn,
    input  fpAddPkg::unpackedT unpacked,
    output fpAddPkg::alignedT  aligned
);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            aligned <= '0;
        end
        else if (loadCount)
        begin
            aligned.shiftedMantissa <= unpacked.smallMantissa;
            aligned.guardBit <= 1'b0;
            aligned.roundBit <= 1'b0;
            aligned.stickyBit <= 1'b0;
        end
        else if (shiftEn)
        begin
            // One position per cycle
            aligned.shiftedMantissa <= {1'b0, aligned.shiftedMantissa[23:1]};
            aligned.guardBit <= aligned.shiftedMantissa[0];
            aligned.roundBit <= aligned.guardBit;
            aligned.stickyBit <= aligned.stickyBit | aligned.roundBit;   // Lost bits stick
        end
    end

endmodule

`default_nettype wire

// ==== hw/mantissaAdder.sv ====
// Effective add or subtract of aligned mantissas with registered carry, exponent and sign
`timescale 1ns/10ps
`default_nettype none

module mantissaAdder (
    input  logic               clk,
    input  logic               arstN,
    input  logic               addEn,
    input  fpAddPkg::unpackedT unpacked,
    input  fpAddPkg::alignedT  aligned,
    output fpAddPkg::sumT      sum
);

    logic [26:0] bigExt;
    logic [26:0] smallExt;
    logic [26:0] total;
    logic        carry;
    logic        isZero;

    always_comb
    begin
        bigExt = {unpacked.bigMantissa, 3'b000};
        smallExt = {aligned.shiftedMantissa, aligned.guardBit, aligned.roundBit,
                    aligned.stickyBit};
        if (unpacked.effSub)
        begin
            carry = 1'b0;
            total = bigExt - smallExt;   // Big magnitude first, never negative
        end
        else
        begin
            {carry, total} = {1'b0, bigExt} + {1'b0, smallExt};
        end
        isZero = (total == '0) && !carry;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            sum <= '0;
        else if (addEn)
        begin
            sum.alignedResult <= total[26:3];
            {sum.guardBit, sum.roundBit, sum.stickyBit} <= total[2:0];
            sum.carryOut <= carry;
            sum.exponentOut <= unpacked.bigExponent;
            sum.alignedSign <= isZero ? 1'b0 : unpacked.bigSign;   // x - x is +0
        end
    end

endmodule

`default_nettype wire

// ==== hw/fpNormalize.sv ====
// Renormalization with special-value selection and round-to-nearest-even, result register
`timescale 1ns/10ps
`default_nettype none

module fpNormalize (
    input  logic                clk,
    input  logic                arstN,
    input  logic                normEn,
    input  fpAddPkg::sumT       sum,
    input  fpAddPkg::fpOperandT rawA,
    input  fpAddPkg::fpOperandT rawB,
    output fpAddPkg::fpOperandT result
);
    import fpAddPkg::*;

    localparam fpOperandT canonicalNan = '{sign: 1'b0, exponent: 8'hff, mantissa: 23'h7fffff};

    logic [4:0]  shiftAmount;
    logic [26:0] shifted;
    logic [24:0] rounded;
    fpOperandT   nextResult;
    logic        aIsNan;
    logic        bIsNan;
    logic        aIsInf;
    logic        bIsInf;

    // Leading zeros of the 24-bit mantissa, 24 when empty
    function automatic logic [4:0] countZeros(input logic [23:0] mant);
        logic [4:0] zeros;
        zeros = 5'd24;
        for (int i = 0; i <= 23; i++)
            if (mant[i])
                zeros = 5'(23 - i);   // Highest set bit wins
        return zeros;
    endfunction

    assign aIsNan = (rawA.exponent == 8'hff) && (rawA.mantissa != '0);
    assign bIsNan = (rawB.exponent == 8'hff) && (rawB.mantissa != '0);
    assign aIsInf = (rawA.exponent == 8'hff) && (rawA.mantissa == '0);
    assign bIsInf = (rawB.exponent == 8'hff) && (rawB.mantissa == '0);

    always_comb
    begin
        shiftAmount = '0;
        shifted = {sum.alignedResult, sum.guardBit, sum.roundBit, sum.stickyBit};
        rounded = '0;
        nextResult = '0;
        nextResult.sign = sum.alignedSign;
        if (sum.exponentOut == 8'h00)
            nextResult.mantissa = sum.alignedResult[22:0];   // Zero or subnormal as is
        else if (sum.exponentOut == 8'hff)
        begin
            if (aIsNan)
                nextResult = rawA;
            else if (bIsNan)
                nextResult = rawB;
            else if (aIsInf && bIsInf)
                nextResult = (rawA.sign == rawB.sign) ? rawA : canonicalNan;
            else if (aIsInf)
                nextResult = rawA;
            else
                nextResult = rawB;
        end
        else if (sum.carryOut)
        begin
            // Carry path truncates
            if (sum.exponentOut == 8'hfe)
            begin
                nextResult.exponent = 8'hff;
                nextResult.mantissa = shifted[25:3];
            end
            else
            begin
                nextResult.exponent = sum.exponentOut + 8'd1;
                nextResult.mantissa = shifted[26:4];
            end
        end
        else if (shifted == '0)
            nextResult.sign = 1'b0;                          // Exact cancellation
        else
        begin
            shiftAmount = countZeros(sum.alignedResult);
            shifted = shifted << shiftAmount;
            if ({3'b000, shiftAmount} > sum.exponentOut)
            begin
                nextResult.exponent = 8'h00;                 // Underflow
                nextResult.mantissa = shifted[25:3];
            end
            else
            begin
                rounded = {1'b0, shifted[26:3]};
                // Half rounds to even, above half rounds up
                if (shifted[2] && (shifted[1] || shifted[0] || shifted[3]))
                    rounded = rounded + 25'd1;
                if (rounded[24])
                begin
                    nextResult.exponent = sum.exponentOut - {3'b000, shiftAmount} + 8'd1;
                    nextResult.mantissa = rounded[23:1];
                end
                else
                begin
                    nextResult.exponent = sum.exponentOut - {3'b000, shiftAmount};
                    nextResult.mantissa = rounded[22:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            result <= '0;
        else if (normEn)
            result <= nextResult;
    end

    // Exponent 255 only from special inputs or overflow near the top
    maxExpSource: assert property (@(posedge clk) disable iff (!arstN)
        normEn |=> (result.exponent != 8'hff) || ($past(sum.exponentOut) >= 8'hfe))
        else $error("result exponent 255 without special input or overflow");

endmodule

`default_nettype wire

// ==== hw/fpAdder.sv ====
// Top level of the multi-cycle adder with controller, counter and datapath stages
`timescale 1ns/10ps
`default_nettype none

module fpAdder #(
    parameter int countWidth = 5
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                start,
    input  fpAddPkg::fpOperandT opA,
    input  fpAddPkg::fpOperandT opB,
    input  logic                sub,
    output fpAddPkg::fpOperandT result,
    output logic                done,
    output logic                busy
);
    import fpAddPkg::*;

    logic      captureEn;
    logic      loadCount;
    logic      shiftEn;
    logic      addEn;
    logic      normEn;
    logic      countZero;
    unpackedT  unpacked;
    fpOperandT rawA;
    fpOperandT rawB;        // Sign already inverted for sub
    alignedT   aligned;
    sumT       sum;

    fpAddCtrl u_ctrl (
        .clk(clk), .arstN(arstN), .start(start), .countZero(countZero),
        .captureEn(captureEn), .loadCount(loadCount), .shiftEn(shiftEn),
        .addEn(addEn), .normEn(normEn), .busy(busy), .done(done)
    );

    alignCounter #(.countWidth(countWidth)) u_counter (
        .clk(clk), .arstN(arstN), .loadCount(loadCount), .shiftEn(shiftEn),
        .expDiff(unpacked.expDiff), .countZero(countZero)
    );

    fpUnpack u_unpack (
        .clk(clk), .arstN(arstN), .captureEn(captureEn), .opA(opA), .opB(opB),
        .sub(sub), .unpacked(unpacked), .rawA(rawA), .rawB(rawB)
    );

    alignShifter u_shifter (
        .clk(clk), .arstN(arstN), .loadCount(loadCount), .shiftEn(shiftEn),
        .unpacked(unpacked), .aligned(aligned)
    );

    mantissaAdder u_adder (
        .clk(clk), .arstN(arstN), .addEn(addEn), .unpacked(unpacked),
        .aligned(aligned), .sum(sum)
    );

    fpNormalize u_normalize (
        .clk(clk), .arstN(arstN), .normEn(normEn), .sum(sum),
        .rawA(rawA), .rawB(rawB), .result(result)
    );

endmodule

`default_nettype wire

// ==== verification/fpAdderChecker.sv ====
// Monitor that compares results, latency, busy and reset values against posted expectations
`timescale 1ns/10ps
`default_nettype none

module fpAdderChecker (
    input  logic                clk,
    input  logic                arstN,
    input  logic                start,
    input  logic                busy,
    input  logic                done,
    input  fpAddPkg::fpOperandT result,
    input  fpAddPkg::fpOperandT expResult,
    input  logic [4:0]          expN,
    input  logic                checkValue,
    input  logic                matchPrev,
    output int                  errorCount,
    output int                  checkCount
);
    import fpAddPkg::*;

    int         errors = 0;
    int         checks = 0;
    int         cycle = 0;
    int         startCycle = 0;
    logic       pending = 1'b0;
    logic       resetSeen = 1'b0;
    fpOperandT  heldResult;
    fpOperandT  prevResult;
    logic [4:0] heldN;
    logic       heldCheck;
    logic       heldPrev;

    assign errorCount = errors;
    assign checkCount = checks;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    // Outputs sampled before the edge updates them
    always @(posedge clk)
    begin
        if (arstN)
        begin
            cycle++;
            if (!resetSeen)
            begin
                resetSeen = 1'b1;
                compare("busy", 32'd0, 32'(busy));
                compare("done", 32'd0, 32'(done));
                compare("result", 32'd0, result);
            end
            if (done)
            begin
                if (!pending)
                begin
                    errors++;
                    $display("Unexpected done pulse without an accepted start at %0t ns", $time);
                end
                else
                begin
                    pending = 1'b0;
                    compare("done latency", 32'(heldN) + 32'd4, cycle - startCycle - 1);
                    if (heldCheck)
                        compare("result", heldPrev ? prevResult : heldResult, result);
                end
                prevResult = result;   // A+B kept for the B+A run
            end
            else if (pending && !busy)
            begin
                errors++;
                $display("Busy dropped before done at %0t ns", $time);
            end
            if (start && !busy)
            begin
                pending = 1'b1;
                startCycle = cycle;
                heldResult = expResult;
                heldN = expN;
                heldCheck = checkValue;
                heldPrev = matchPrev;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/fpAdderTb.sv ====
// Testbench top with clock, reset, vector table, random pairs, stimulus loop and watchdog
`timescale 1ns/10ps
`default_nettype none

module fpAdderTb;
    import fpAddPkg::*;

    typedef struct packed {
        fpOperandT  a;
        fpOperandT  b;
        logic       sub;
        fpOperandT  expected;
        logic [4:0] n;
    } vectorT;

    localparam int tableRows = 19;
    localparam int randomPairs = 40;
    localparam int resetCycles = 10;
    localparam int doneTimeout = 40;
    // Three runs per random pair, each well under 40 cycles
    localparam int watchdogCycles = (tableRows + 3 * randomPairs) * 40 + resetCycles + 10;

    // opA, opB, sub, expected result, expected alignment shifts
    localparam vectorT vectors [tableRows] = '{
        '{32'h3f80_0000, 32'h4000_0000, 1'b0, 32'h4040_0000, 5'd1},    // 1.0 + 2.0
        '{32'h4060_0000, 32'h3fa0_0000, 1'b1, 32'h4010_0000, 5'd1},    // 3.5 - 1.25
        '{32'h3fc0_0000, 32'h3fc0_0000, 1'b0, 32'h4040_0000, 5'd0},    // Carry out, exact
        '{32'h3f80_0000, 32'h3f40_0000, 1'b1, 32'h3e80_0000, 5'd1},    // 1.0 - 0.75
        '{32'h3f80_0000, 32'h4040_0000, 1'b1, 32'hc000_0000, 5'd1},    // Negative result
        '{32'h3f80_0000, 32'h3380_0000, 1'b0, 32'h3f80_0000, 5'd24},   // Tie, stays even
        '{32'h3f80_0001, 32'h3380_0000, 1'b0, 32'h3f80_0002, 5'd24},   // Tie, up to even
        '{32'h3f80_0000, 32'h33c0_0000, 1'b0, 32'h3f80_0001, 5'd24},   // Above half
        '{32'h3f80_0000, 32'h3300_0000, 1'b0, 32'h3f80_0000, 5'd25},   // Below half
        '{32'h3f80_0000, 32'h2b80_0000, 1'b0, 32'h3f80_0000, 5'd26},   // Sticky only
        '{32'h3f80_0000, 32'h2b80_0000, 1'b1, 32'h3f80_0000, 5'd26},
        '{32'h7fc0_0001, 32'h3f80_0000, 1'b0, 32'h7fc0_0001, 5'd26},   // NaN in A
        '{32'h3f80_0000, 32'h7f80_0123, 1'b0, 32'h7f80_0123, 5'd26},   // NaN in B
        '{32'h7f80_0000, 32'h7f80_0000, 1'b0, 32'h7f80_0000, 5'd0},
        '{32'h7f80_0000, 32'h7f80_0000, 1'b1, 32'h7fff_ffff, 5'd0},    // inf - inf
        '{32'hff80_0000, 32'h4000_0000, 1'b0, 32'hff80_0000, 5'd26},
        '{32'h7f00_0000, 32'h7f00_0000, 1'b0, 32'h7f80_0000, 5'd0},    // Overflow
        '{32'h4049_0fdb, 32'h4049_0fdb, 1'b1, 32'h0000_0000, 5'd0},
        '{32'hc020_0000, 32'hc020_0000, 1'b1, 32'h0000_0000, 5'd0}
    };

    logic        clk = 1'b0;
    logic        arstN;
    logic        start;
    fpOperandT   opA;
    fpOperandT   opB;
    logic        sub;
    fpOperandT   result;
    logic        done;
    logic        busy;
    fpOperandT   expResult;
    logic [4:0]  expN;
    logic        checkValue;
    logic        matchPrev;
    int          checkerErrors;
    int          checkerChecks;
    int          tbErrors;
    logic [31:0] lcgState;

    always #5 clk = ~clk;

    fpAdder #(.countWidth(5)) u_dut (
        .clk(clk), .arstN(arstN), .start(start), .opA(opA), .opB(opB), .sub(sub),
        .result(result), .done(done), .busy(busy)
    );

    fpAdderChecker u_checker (
        .clk(clk), .arstN(arstN), .start(start), .busy(busy), .done(done),
        .result(result), .expResult(expResult), .expN(expN), .checkValue(checkValue),
        .matchPrev(matchPrev), .errorCount(checkerErrors), .checkCount(checkerChecks)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Shifts before the add, capped where only sticky changes
    function automatic logic [4:0] shiftCount(input logic [7:0] expA, input logic [7:0] expB);
        int diff;
        diff = int'(expA) - int'(expB);
        if (diff < 0)
            diff = -diff;
        return (diff > 26) ? 5'd26 : 5'(diff);
    endfunction

    task automatic drawOperand(output fpOperandT op);
        lcgState = lcgNext(lcgState);
        op.sign = lcgState[31];
        op.exponent = 8'(1 + (lcgState[30:23] % 200));   // Normal, 1 to 200
        lcgState = lcgNext(lcgState);
        op.mantissa = lcgState[31:9];
    endtask

    task automatic waitForDone(input string label);
        int waited;
        waited = 0;
        while (!done && waited < doneTimeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
        begin
            tbErrors++;
            $display("No done pulse within %0d cycles for %s", doneTimeout, label);
        end
    endtask

    // Called on a falling edge with the DUT idle
    task automatic runOperation(input fpOperandT a, input fpOperandT b, input logic subFlag,
                                input fpOperandT expected, input logic [4:0] n,
                                input logic valueCheck, input logic againstPrev,
                                input logic pokeWhileBusy, input string label);
        opA = a;
        opB = b;
        sub = subFlag;
        expResult = expected;
        expN = n;
        checkValue = valueCheck;
        matchPrev = againstPrev;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (pokeWhileBusy)
        begin
            @(negedge clk);
            opA = ~a;   // Must not be captured
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        waitForDone(label);
        @(negedge clk);
    endtask

    initial
    begin
        fpOperandT  randA;
        fpOperandT  randB;
        logic [4:0] n;
        arstN = 1'b0;
        start = 1'b0;
        opA = '0;
        opB = '0;
        sub = 1'b0;
        expResult = '0;
        expN = '0;
        checkValue = 1'b0;
        matchPrev = 1'b0;
        tbErrors = 0;
        lcgState = 32'h28fb_e449;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        repeat (2) @(negedge clk);

        for (int i = 0; i < tableRows; i++)
            runOperation(vectors[i].a, vectors[i].b, vectors[i].sub, vectors[i].expected,
                         vectors[i].n, 1'b1, 1'b0, 1'b1, $sformatf("table row %0d", i));

        for (int i = 0; i < randomPairs; i++)
        begin
            drawOperand(randA);
            drawOperand(randB);
            n = shiftCount(randA.exponent, randB.exponent);
            runOperation(randA, randB, 1'b0, '0, n, 1'b0, 1'b0, 1'b0,
                         $sformatf("random pair %0d, A + B", i));
            runOperation(randB, randA, 1'b0, '0, n, 1'b1, 1'b1, 1'b0,
                         $sformatf("random pair %0d, B + A", i));
            runOperation(randA, randA, 1'b1, '0, 5'd0, 1'b1, 1'b0, 1'b0,
                         $sformatf("random pair %0d, A - A", i));
        end

        $display("Totals: %0d checks, %0d errors", checkerChecks, checkerErrors + tbErrors);
        if (checkerErrors + tbErrors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", watchdogCycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/fpAddPkg.sv
hw/fpAddCtrl.sv
hw/alignCounter.sv
hw/fpUnpack.sv
hw/alignShifter.sv
hw/mantissaAdder.sv
hw/fpNormalize.sv
hw/fpAdder.sv
verification/fpAdderChecker.sv
verification/fpAdderTb.sv

// ==== Makefile ====
# Verilator build, run and lint for the multi-cycle floating-point adder

TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = fpAdderTb
RTL_TOP   = fpAdder
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_TEXT = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP)

run: build
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
